//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

	typedef logic [31:0] word_t;     // data and address word
	typedef logic [31:0] inst_t;     // raw instruction
	typedef logic [4:0]  reg_addr_t; // x0..x31

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b // lui
	} alu_op_t;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_wait,
		fetch_exec
	} fetch_state_t;

	// major opcodes of the supported subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// alu group funct3, shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

//--- verilog/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import rv_core_pkg::*; (
	input  logic  clk,
	input  logic  rst,

	output logic  imem_req_o,
	output word_t imem_addr_o,
	input  inst_t imem_rdata_i,

	input  word_t next_pc_i,
	input  logic  illegal_i,

	output inst_t inst_o,
	output word_t pc_o,
	output logic  exec_en_o,
	output logic  halt_o
);

	fetch_state_t state_q;
	fetch_state_t state_d;
	word_t        pc_q;
	inst_t        inst_q;
	logic         run_q;  // high from the first cycle out of reset
	logic         halt_q;
	logic         issue;

	assign issue       = (state_q == fetch_idle) && run_q && !halt_q;
	assign imem_req_o  = issue;
	assign imem_addr_o = pc_q;

	// an illegal instruction never gets its execute cycle
	assign exec_en_o = (state_q == fetch_exec) && !illegal_i;

	assign inst_o = inst_q;
	assign pc_o   = pc_q;
	assign halt_o = halt_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_idle: begin
				if (issue)
					state_d = fetch_wait;
			end
			fetch_wait: state_d = fetch_exec; // rdata arrives now
			fetch_exec: state_d = fetch_idle;
			default:    state_d = fetch_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= fetch_idle;
			run_q   <= 1'b0;
			halt_q  <= 1'b0;
			pc_q    <= RESET_PC;
		end else begin
			state_q <= state_d;
			run_q   <= 1'b1;
			if (state_q == fetch_exec && illegal_i)
				halt_q <= 1'b1; // sticky until reset
			if (exec_en_o)
				pc_q <= next_pc_i;
		end
	end

	// instruction register
	always_ff @(posedge clk) begin
		if (state_q == fetch_wait)
			inst_q <= imem_rdata_i;
	end

	// illegal in execute halts the core from the next cycle, with no request
	a_halt_on_illegal: assert property (@(posedge clk) disable iff (rst)
		(state_q == fetch_exec && illegal_i) |=> (halt_o && !imem_req_o));

	a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
		halt_o |=> (halt_o && !imem_req_o));

	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		state_q inside {fetch_idle, fetch_wait, fetch_exec});

endmodule

//--- verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_core_pkg::*; (
	input  inst_t     inst_i,

	output reg_addr_t rs1_o,
	output reg_addr_t rs2_o,
	output reg_addr_t rd_o,
	output word_t     imm_o,
	output alu_op_t   alu_op_o,

	output logic      src_a_pc_o,
	output logic      src_b_imm_o,
	output logic      branch_o,
	output logic      jal_o,
	output logic      jalr_o,
	output logic      wb_en_o,
	output logic [2:0] funct3_o,
	output logic      illegal_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i_type;
	word_t      imm_u_type;
	word_t      imm_j_type;
	word_t      imm_b_type;
	alu_op_t    alu_fn;
	logic       use_sub;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign rs1_o    = inst_i[19:15];
	assign rs2_o    = inst_i[24:20];
	assign rd_o     = inst_i[11:7];
	assign funct3_o = funct3;

	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u_type = {inst_i[31:12], 12'b0};
	assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

	// addi ignores bit 30, only the register form has sub
	assign use_sub = (opcode == OPC_OP) && funct7[5];

	always_comb begin
		case (funct3)
			F3_ADD:  alu_fn = use_sub ? alu_sub : alu_add;
			F3_SLL:  alu_fn = alu_sll;
			F3_SLT:  alu_fn = alu_slt;
			F3_SLTU: alu_fn = alu_sltu;
			F3_XOR:  alu_fn = alu_xor;
			F3_SR:   alu_fn = funct7[5] ? alu_sra : alu_srl;
			F3_OR:   alu_fn = alu_or;
			default: alu_fn = alu_and;
		endcase
	end

	always_comb begin
		alu_op_o    = alu_add;
		imm_o       = imm_i_type;
		src_a_pc_o  = 1'b0;
		src_b_imm_o = 1'b0;
		branch_o    = 1'b0;
		jal_o       = 1'b0;
		jalr_o      = 1'b0;
		wb_en_o     = 1'b0;
		illegal_o   = 1'b0;

		case (opcode)
			OPC_LUI: begin
				imm_o       = imm_u_type;
				alu_op_o    = alu_pass_b;
				src_b_imm_o = 1'b1;
				wb_en_o     = 1'b1;
			end
			OPC_AUIPC: begin
				imm_o       = imm_u_type;
				src_a_pc_o  = 1'b1;
				src_b_imm_o = 1'b1;
				wb_en_o     = 1'b1;
			end
			OPC_JAL: begin
				imm_o   = imm_j_type;
				jal_o   = 1'b1;
				wb_en_o = 1'b1;
			end
			OPC_JALR: begin
				src_b_imm_o = 1'b1; // alu forms rs1 + imm
				jalr_o      = 1'b1;
				wb_en_o     = 1'b1;
				illegal_o   = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				imm_o     = imm_b_type;
				branch_o  = 1'b1;
				illegal_o = (funct3 == 3'b010) || (funct3 == 3'b011);
			end
			OPC_OP_IMM: begin
				alu_op_o    = alu_fn;
				src_b_imm_o = 1'b1;
				wb_en_o     = 1'b1;
				if (funct3 == F3_SLL && funct7 != F7_BASE)
					illegal_o = 1'b1;
				if (funct3 == F3_SR && funct7 != F7_BASE && funct7 != F7_ALT)
					illegal_o = 1'b1;
			end
			OPC_OP: begin
				alu_op_o = alu_fn;
				wb_en_o  = 1'b1;
				// alt funct7 only for sub and sra
				if (funct7 != F7_BASE &&
						!(funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)))
					illegal_o = 1'b1;
			end
			default: illegal_o = 1'b1;
		endcase

		if (illegal_o)
			wb_en_o = 1'b0;
	end

endmodule

//--- verilog/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
	input  word_t      pc_i,
	input  word_t      rs1_data_i,
	input  word_t      rs2_data_i,
	input  word_t      imm_i,

	input  alu_op_t    alu_op_i,
	input  logic       src_a_pc_i,
	input  logic       src_b_imm_i,

	input  logic       branch_i,
	input  logic       jal_i,
	input  logic       jalr_i,
	input  logic [2:0] funct3_i,

	output word_t      result_o,
	output word_t      next_pc_o
);

	word_t    op_a;
	word_t    op_b;
	word_t    alu_res;
	word_t    pc_plus4;
	word_t    target;   // pc relative, for branch and jal
	word_t    next_raw;
	logic [4:0] shamt;
	logic     eq;
	logic     lt_s;
	logic     lt_u;
	logic     taken;

	assign op_a  = src_a_pc_i ? pc_i : rs1_data_i;
	assign op_b  = src_b_imm_i ? imm_i : rs2_data_i;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op_i)
			alu_add:    alu_res = op_a + op_b;
			alu_sub:    alu_res = op_a - op_b;
			alu_sll:    alu_res = op_a << shamt;
			alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			alu_sltu:   alu_res = {31'b0, op_a < op_b};
			alu_xor:    alu_res = op_a ^ op_b;
			alu_srl:    alu_res = op_a >> shamt;
			alu_sra:    alu_res = word_t'($signed(op_a) >>> shamt);
			alu_or:     alu_res = op_a | op_b;
			alu_and:    alu_res = op_a & op_b;
			alu_pass_b: alu_res = op_b;
			default:    alu_res = '0;
		endcase
	end

	// branch compare always on the register pair
	assign eq   = (rs1_data_i == rs2_data_i);
	assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
	assign lt_u = (rs1_data_i < rs2_data_i);

	always_comb begin
		case (funct3_i)
			F3_BEQ:  taken = eq;
			F3_BNE:  taken = !eq;
			F3_BLT:  taken = lt_s;
			F3_BGE:  taken = !lt_s;
			F3_BLTU: taken = lt_u;
			F3_BGEU: taken = !lt_u;
			default: taken = 1'b0;
		endcase
	end

	assign pc_plus4 = pc_i + 32'd4;
	assign target   = pc_i + imm_i;

	always_comb begin
		if (jalr_i)
			next_raw = alu_res; // rs1 + imm
		else if (jal_i || (branch_i && taken))
			next_raw = target;
		else
			next_raw = pc_plus4;
	end

	assign next_pc_o = {next_raw[31:2], 2'b00};
	assign result_o  = (jal_i || jalr_i) ? pc_plus4 : alu_res; // link value on jumps

	always_comb begin
		a_next_pc_aligned: assert final (next_pc_o[1:0] == 2'b00);
	end

endmodule

//--- verilog/rv_result.sv
`timescale 1ns/1ps

module rv_result import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      rst,

	input  logic      exec_en_i,
	input  logic      wb_en_i,

	input  reg_addr_t rd_i,
	input  reg_addr_t rs1_i,
	input  reg_addr_t rs2_i,

	input  word_t     result_i,
	input  word_t     pc_i,
	input  word_t     next_pc_i,

	output word_t     rs1_data_o,
	output word_t     rs2_data_o,

	output logic      retire_valid_o,
	output word_t     retire_pc_o,
	output reg_addr_t retire_rd_o,
	output word_t     retire_data_o,
	output word_t     retire_next_pc_o
);

	word_t regs [1:31]; // x0 is not stored

	assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
	assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

	always_ff @(posedge clk) begin
		if (exec_en_i && wb_en_i && rd_i != 5'd0)
			regs[rd_i] <= result_i;
	end

	always_ff @(posedge clk) begin
		if (rst)
			retire_valid_o <= 1'b0;
		else
			retire_valid_o <= exec_en_i; // one pulse per executed instruction
	end

	// branches report rd 0, data 0
	always_ff @(posedge clk) begin
		if (exec_en_i) begin
			retire_pc_o      <= pc_i;
			retire_rd_o      <= wb_en_i ? rd_i : 5'd0;
			retire_data_o    <= wb_en_i ? result_i : '0;
			retire_next_pc_o <= next_pc_i;
		end
	end

	// one execute cycle per instruction, so retire never repeats back to back
	a_retire_single_pulse: assert property (@(posedge clk) disable iff (rst)
		retire_valid_o |=> !retire_valid_o);

endmodule

//--- verilog/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      rst,

	output logic      imem_req_o,
	output word_t     imem_addr_o,
	input  inst_t     imem_rdata_i,

	output logic      retire_valid_o,
	output word_t     retire_pc_o,
	output reg_addr_t retire_rd_o,
	output word_t     retire_data_o,
	output word_t     retire_next_pc_o,

	output logic      halt_o
);

	inst_t      inst;
	word_t      pc;
	logic       exec_en;
	word_t      next_pc;

	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd;
	word_t      imm;
	alu_op_t    alu_op;
	logic       src_a_pc;
	logic       src_b_imm;
	logic       branch;
	logic       jal;
	logic       jalr;
	logic       wb_en;
	logic [2:0] funct3;
	logic       illegal;

	word_t      rs1_data;
	word_t      rs2_data;
	word_t      result;

	rv_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.imem_req_o   (imem_req_o),
		.imem_addr_o  (imem_addr_o),
		.imem_rdata_i (imem_rdata_i),
		.next_pc_i    (next_pc),
		.illegal_i    (illegal),
		.inst_o       (inst),
		.pc_o         (pc),
		.exec_en_o    (exec_en),
		.halt_o       (halt_o)
	);

	rv_decode u_decode (
		.inst_i      (inst),
		.rs1_o       (rs1),
		.rs2_o       (rs2),
		.rd_o        (rd),
		.imm_o       (imm),
		.alu_op_o    (alu_op),
		.src_a_pc_o  (src_a_pc),
		.src_b_imm_o (src_b_imm),
		.branch_o    (branch),
		.jal_o       (jal),
		.jalr_o      (jalr),
		.wb_en_o     (wb_en),
		.funct3_o    (funct3),
		.illegal_o   (illegal)
	);

	rv_execute u_execute (
		.pc_i        (pc),
		.rs1_data_i  (rs1_data),
		.rs2_data_i  (rs2_data),
		.imm_i       (imm),
		.alu_op_i    (alu_op),
		.src_a_pc_i  (src_a_pc),
		.src_b_imm_i (src_b_imm),
		.branch_i    (branch),
		.jal_i       (jal),
		.jalr_i      (jalr),
		.funct3_i    (funct3),
		.result_o    (result),
		.next_pc_o   (next_pc)
	);

	rv_result u_result (
		.clk              (clk),
		.rst              (rst),
		.exec_en_i        (exec_en),
		.wb_en_i          (wb_en),
		.rd_i             (rd),
		.rs1_i            (rs1),
		.rs2_i            (rs2),
		.result_i         (result),
		.pc_i             (pc),
		.next_pc_i        (next_pc),
		.rs1_data_o       (rs1_data),
		.rs2_data_o       (rs2_data),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_next_pc_o (retire_next_pc_o)
	);

endmodule

//--- bench/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

logic [31:0] ref_regs [0:31]; // architectural registers, x0 never read
logic [31:0] ref_pc;
logic [11:0] grp_a;           // first operand of the current branch group

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	logic [31:0] r;
	case (f3)
		3'd0: r = alt ? a - b : a + b;
		3'd1: r = a << b[4:0];
		3'd2: r = {31'b0, $signed(a) < $signed(b)};
		3'd3: r = {31'b0, a < b};
		3'd4: r = a ^ b;
		3'd5: begin
			if (alt)
				r = $signed(a) >>> b[4:0];
			else
				r = a >> b[4:0];
		end
		3'd6: r = a | b;
		default: r = a & b;
	endcase
	return r;
endfunction

// one architectural step, returns what the retire port should show
function automatic void ref_step(input logic [31:0] ins, output logic [31:0] pc,
		output logic [4:0] rd, output logic [31:0] data, output logic [31:0] npc);
	logic [4:0]  dst;
	logic [2:0]  f3;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] imm_b;
	logic        wb;
	logic        taken;
	dst   = ins[11:7];
	f3    = ins[14:12];
	a     = (ins[19:15] == 5'd0) ? 32'd0 : ref_regs[ins[19:15]];
	b     = (ins[24:20] == 5'd0) ? 32'd0 : ref_regs[ins[24:20]];
	imm_i = {{20{ins[31]}}, ins[31:20]};
	imm_u = {ins[31:12], 12'b0};
	imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	pc    = ref_pc;
	npc   = ref_pc + 32'd4;
	wb    = 1'b1;
	taken = 1'b0;
	data  = 32'd0;
	case (ins[6:0])
		OPC_LUI:   data = imm_u;
		OPC_AUIPC: data = ref_pc + imm_u;
		OPC_JAL: begin
			data = ref_pc + 32'd4;
			npc  = ref_pc + imm_j;
		end
		OPC_JALR: begin
			data = ref_pc + 32'd4;
			npc  = a + imm_i;
		end
		OPC_BRANCH: begin
			wb = 1'b0;
			case (f3)
				3'b000:  taken = (a == b);
				3'b001:  taken = (a != b);
				3'b100:  taken = $signed(a) < $signed(b);
				3'b101:  taken = $signed(a) >= $signed(b);
				3'b110:  taken = a < b;
				default: taken = a >= b;
			endcase
			if (taken)
				npc = ref_pc + imm_b;
		end
		OPC_OP_IMM: data = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
		default:    data = alu_ref(f3, ins[30], a, b); // register group
	endcase
	npc[1:0] = 2'b00;
	rd = wb ? dst : 5'd0;
	if (wb && dst != 5'd0)
		ref_regs[dst] = data;
	ref_pc = npc;
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic logic [2:0] br_f3(input logic [2:0] sel);
	logic [2:0] f3;
	case (sel % 6)
		0:       f3 = 3'b000;
		1:       f3 = 3'b001;
		2:       f3 = 3'b100;
		3:       f3 = 3'b101;
		4:       f3 = 3'b110;
		default: f3 = 3'b111;
	endcase
	return f3;
endfunction

function automatic logic [31:0] rand_alu();
	logic [31:0] r;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [11:0] imm;
	r  = $random(seed);
	f3 = r[2:0];
	if (r[18]) begin
		f7 = (r[19] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0;
		return enc_r(f7, r[17:13], r[12:8], f3, r[7:3]);
	end
	imm = r[31:20];
	if (f3 == 3'd1)
		imm = {7'b0, r[24:20]}; // slli
	else if (f3 == 3'd5)
		imm = {1'b0, r[19], 5'b0, r[24:20]}; // srli or srai
	return enc_i(imm, r[12:8], f3, r[7:3], OPC_OP_IMM);
endfunction

function automatic logic [31:0] rand_jump();
	logic [31:0] r;
	logic [31:0] w;
	logic [3:0]  k;
	logic [20:0] joff;
	r    = $random(seed);
	k    = {1'b0, r[15:13]} + 4'd1;
	joff = {15'b0, k, 2'b0};
	if (r[16])
		joff = -joff;
	case (r[2:0])
		3'd0, 3'd1: w = {r[31:12], r[7:3], OPC_LUI};
		3'd2:       w = {r[31:12], r[7:3], OPC_AUIPC};
		3'd3, 3'd4: w = enc_j(joff, r[7:3]);
		3'd5:       w = enc_i(r[31:20], r[12:8], 3'b000, r[7:3], OPC_JALR);
		default:    w = rand_alu();
	endcase
	return w;
endfunction

function automatic logic [31:0] rand_branch();
	logic [31:0] r;
	logic [3:0]  k;
	logic [12:0] boff;
	r    = $random(seed);
	k    = {1'b0, r[15:13]} + 4'd1;
	boff = {7'b0, k, 2'b0};
	if (r[16])
		boff = -boff;
	return enc_b(boff, r[17:13], r[12:8], br_f3(r[5:3]));
endfunction

// groups of four words: set x1, set x2, branch to another group, add
function automatic logic [31:0] group_inst(input int idx);
	logic [31:0] r;
	logic [31:0] w;
	logic [11:0] b;
	logic [2:0]  k;
	logic [12:0] boff;
	r = $random(seed);
	case (idx % 4)
		0: begin
			grp_a = r[11:0];
			w = enc_i(grp_a, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);
		end
		1: begin
			case (r[13:12])
				2'd0:    b = grp_a;         // equal
				2'd1:    b = grp_a + 12'd1;
				2'd2:    b = grp_a - 12'd1;
				default: b = r[11:0];
			endcase
			w = enc_i(b, 5'd0, 3'b000, 5'd2, OPC_OP_IMM);
		end
		2: begin
			k    = {1'b0, r[1:0]} + 3'd1;
			boff = {6'b0, k, 4'b0};
			if (r[2])
				boff = -boff;
			if (r[6])
				w = enc_b(boff, 5'd1, 5'd2, br_f3(r[5:3]));
			else
				w = enc_b(boff, 5'd2, 5'd1, br_f3(r[5:3]));
		end
		default: w = enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd3);
	endcase
	return w;
endfunction

function automatic logic [31:0] gen_inst(input int kind, input int idx);
	logic [31:0] sel;
	logic [31:0] w;
	case (kind)
		1: w = rand_alu();
		2: w = rand_jump();
		3: w = group_inst(idx);
		default: begin
			sel = $random(seed);
			if (sel[1:0] == 2'd0)
				w = rand_jump();
			else if (sel[1:0] == 2'd1)
				w = rand_branch();
			else
				w = rand_alu();
		end
	endcase
	return w;
endfunction

`endif

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*; ();

	localparam int N_INIT      = 31;
	localparam int N_ALU       = 100;
	localparam int N_JUMP      = 100;
	localparam int N_BRANCH    = 120;
	localparam int N_MIXED     = 100;
	localparam int N_PREFIX    = 4;
	localparam int HALT_CYCLES = 20;
	localparam int NUM_TESTS   = 6;
	localparam int TOTAL_INSTS = N_INIT + N_ALU + N_JUMP + N_BRANCH + N_MIXED + N_PREFIX;
	// three cycles per instruction, reset and start-up per test, the halt window
	localparam int CYCLE_LIMIT = 3 * TOTAL_INSTS + 10 * NUM_TESTS + HALT_CYCLES + 50;
	localparam logic [31:0] ILLEGAL_WORD = 32'h0000_000B; // custom-0 opcode
	localparam logic [31:0] START_ADDR   = 32'h0000_0000;

	logic        clk = 1'b0;
	logic        rst;
	logic        imem_req_o;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_rdata;
	logic        retire_valid_o;
	logic [31:0] retire_pc_o;
	logic [4:0]  retire_rd_o;
	logic [31:0] retire_data_o;
	logic [31:0] retire_next_pc_o;
	logic        halt_o;

	integer      seed = 32'h7332;
	logic [31:0] mem [0:255];
	int          errors = 0;
	int          test_errors = 0;
	int          retired = 0;
	int          cycles = 0;
	int          last_cycle = 0;
	logic        have_last = 1'b0;
	logic        first_req_pending = 1'b0;
	logic [31:0] e_pc;
	logic [4:0]  e_rd;
	logic [31:0] e_data;
	logic [31:0] e_npc;

	`include "rv_ref_model.svh"

	always #2 clk = ~clk;

	rv_core_top dut (
		.clk              (clk),
		.rst              (rst),
		.imem_req_o       (imem_req_o),
		.imem_addr_o      (imem_addr_o),
		.imem_rdata_i     (imem_rdata),
		.retire_valid_o   (retire_valid_o),
		.retire_pc_o      (retire_pc_o),
		.retire_rd_o      (retire_rd_o),
		.retire_data_o    (retire_data_o),
		.retire_next_pc_o (retire_next_pc_o),
		.halt_o           (halt_o)
	);

	// instruction memory, read data one cycle after the strobe
	always @(posedge clk) begin
		if (imem_req_o)
			imem_rdata <= mem[imem_addr_o[9:2]];
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	// compare process, also counts cycles for the timeout
	always @(posedge clk) begin
		cycles++;
		if (imem_req_o && first_req_pending) begin
			check("imem_addr_o", imem_addr_o, START_ADDR);
			first_req_pending = 1'b0;
		end
		if (retire_valid_o) begin
			ref_step(mem[ref_pc[9:2]], e_pc, e_rd, e_data, e_npc);
			check("retire_pc_o", retire_pc_o, e_pc);
			check("retire_rd_o", retire_rd_o, e_rd);
			check("retire_data_o", retire_data_o, e_data);
			check("retire_next_pc_o", retire_next_pc_o, e_npc);
			check("imem_req_o", imem_req_o, 1); // next fetch in the retire cycle
			if (have_last)
				check("retire gap", cycles - last_cycle, 3);
			last_cycle = cycles;
			have_last  = 1'b1;
			retired++;
		end
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// caller sits on a rising edge, or at time zero
	task apply_reset();
		int i;
		rst <= 1'b1;
		for (i = 0; i < 3; i++) begin
			@(posedge clk);
			if (i > 0) begin // outputs settle after the first reset edge
				check("imem_req_o", imem_req_o, 0);
				check("retire_valid_o", retire_valid_o, 0);
				check("halt_o", halt_o, 0);
			end
		end
		rst <= 1'b0;
		ref_pc            = START_ADDR;
		have_last         = 1'b0;
		retired           = 0;
		test_errors       = 0;
		first_req_pending = 1'b1;
	endtask

	task load_program(input int kind);
		int i;
		for (i = 0; i < 256; i++)
			mem[i] = gen_inst(kind, i);
	endtask

	task run_test(input int n, input string name);
		apply_reset();
		wait (retired == n);
		rst <= 1'b1; // on the last retire edge, so the next execute never happens
		$display("test %-26s %4d retired, %0d mismatches", name, retired, test_errors);
	endtask

	initial begin
		int          i;
		logic [31:0] rnd;
		rst        = 1'b1;
		imem_rdata = '0;

		// every register gets a value before any test reads it
		load_program(1);
		for (i = 0; i < N_INIT; i++) begin
			rnd    = $random(seed);
			mem[i] = {rnd[31:12], 5'(i + 1), OPC_LUI};
		end
		run_test(N_INIT, "reset and register init");

		load_program(1);
		run_test(N_ALU, "alu register and immediate");
		load_program(2);
		run_test(N_JUMP, "lui auipc jal jalr");
		load_program(3);
		run_test(N_BRANCH, "branch conditions");
		load_program(4);
		run_test(N_MIXED, "retire timing");

		load_program(1);
		mem[N_PREFIX] = ILLEGAL_WORD;
		apply_reset();
		wait (retired == N_PREFIX);
		wait (halt_o);
		repeat (HALT_CYCLES) begin
			@(posedge clk);
			check("imem_req_o", imem_req_o, 0);
			check("retire_valid_o", retire_valid_o, 0);
			check("halt_o", halt_o, 1);
		end
		check("retire count", retired, N_PREFIX);
		$display("test %-26s %4d retired, %0d mismatches", "illegal halt", retired,
			test_errors);

		$display("%0d tests, %0d failed checks", NUM_TESTS, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- list.f
verilog/rv_core_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core_top.sv
+incdir+bench
bench/tb_rv_core.sv
